// File: build.f
hw/rv32_exec_pkg.sv
hw/control_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/branch_resolver.sv
hw/mem_lane_unit.sv
hw/execute_stage.sv
hw/data_ram.sv
hw/exec_core.sv
tests/tb_exec_core.sv

// File: hw/alu.sv
// Integer ALU
`timescale 1ns/1ns

module alu (
    input  rv32_exec_pkg::alu_op_t aluop,
    input  rv32_exec_pkg::word_t   port_a,
    input  rv32_exec_pkg::word_t   port_b,
    output rv32_exec_pkg::word_t   port_out
);
    import rv32_exec_pkg::*;

    logic [4:0] shamt;

    assign shamt = port_b[4:0];

    always_comb begin
        case (aluop)
            ADD:     port_out = port_a + port_b;
            SUB:     port_out = port_a - port_b;
            SLL:     port_out = port_a << shamt;
            SLT:     port_out = word_t'($signed(port_a) < $signed(port_b));
            SLTU:    port_out = word_t'(port_a < port_b);
            XOR:     port_out = port_a ^ port_b;
            SRL:     port_out = port_a >> shamt;
            SRA:     port_out = word_t'($signed(port_a) >>> shamt);
            OR:      port_out = port_a | port_b;
            AND:     port_out = port_a & port_b;
            default: port_out = '0;
        endcase
    end

endmodule

// File: hw/branch_resolver.sv
// Branch and jump resolution
`timescale 1ns/1ns

module branch_resolver (
    input  rv32_exec_pkg::word_t rs1_data,
    input  rv32_exec_pkg::word_t rs2_data,
    input  rv32_exec_pkg::word_t pc,
    input  rv32_exec_pkg::ctrl_t ctrl,
    output logic                 taken,
    output rv32_exec_pkg::word_t target
);
    import rv32_exec_pkg::*;

    logic  cond;
    word_t jalr_sum;

    always_comb begin
        case (ctrl.branch_type)
            BEQ:     cond = (rs1_data == rs2_data);
            BNE:     cond = (rs1_data != rs2_data);
            BLT:     cond = ($signed(rs1_data) < $signed(rs2_data));
            BGE:     cond = ($signed(rs1_data) >= $signed(rs2_data));
            BLTU:    cond = (rs1_data < rs2_data);
            BGEU:    cond = (rs1_data >= rs2_data);
            default: cond = 1'b0;
        endcase
    end

    assign taken    = ctrl.branch && cond;
    assign jalr_sum = rs1_data + ctrl.imm_i;

    // JALR target has bit 0 forced low
    assign target = ctrl.jal  ? pc + ctrl.imm_j :
                    ctrl.jalr ? {jalr_sum[31:1], 1'b0} :
                                pc + ctrl.imm_b;

endmodule

// File: hw/control_decoder.sv
// Instruction decoder
`timescale 1ns/1ns

module control_decoder (
    input  rv32_exec_pkg::word_t instr,
    output rv32_exec_pkg::ctrl_t ctrl
);
    import rv32_exec_pkg::*;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam word_t      HALT_INSTR = 32'h0000_0073;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt_op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // instr[30] selects SUB and SRA, and only for those funct3 values
    assign alt_op = instr[30] &&
                    ((funct3 == 3'b101) || ((opcode == OPC_OP) && (funct3 == 3'b000)));

    always_comb begin
        ctrl             = '0;
        ctrl.alu_op      = ADD;
        ctrl.load_type   = LW;
        ctrl.branch_type = BEQ;
        ctrl.rs1         = instr[19:15];
        ctrl.rs2         = instr[24:20];
        ctrl.rd          = instr[11:7];
        ctrl.imm_i       = {{20{instr[31]}}, instr[31:20]};
        ctrl.imm_s       = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        ctrl.imm_b       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
        ctrl.imm_u       = {instr[31:12], 12'b0};
        ctrl.imm_j       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};

        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                ctrl.alu_op  = alu_op_t'({alt_op, funct3});
                ctrl.b_sel   = (opcode == OPC_OP) ? B_RS2 : B_IMM_I;
                ctrl.reg_wen = 1'b1;
            end
            OPC_LUI: begin
                ctrl.wb_sel  = WB_IMM_U;
                ctrl.reg_wen = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl.a_sel   = A_PC;
                ctrl.b_sel   = B_IMM_U;
                ctrl.reg_wen = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                ctrl.jal     = (opcode == OPC_JAL);
                ctrl.jalr    = (opcode == OPC_JALR);
                ctrl.wb_sel  = WB_PC4;
                ctrl.reg_wen = 1'b1;
            end
            OPC_BRANCH: begin
                // funct3 010 and 011 are not branches
                ctrl.illegal = (funct3[2:1] == 2'b01);
                ctrl.branch  = !ctrl.illegal;
                if (!ctrl.illegal) begin
                    ctrl.branch_type = branch_type_t'(funct3);
                end
            end
            OPC_LOAD: begin
                ctrl.illegal = !(funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101});
                ctrl.dren    = !ctrl.illegal;
                ctrl.reg_wen = !ctrl.illegal;
                ctrl.b_sel   = B_IMM_I;
                ctrl.wb_sel  = WB_LOAD;
                if (!ctrl.illegal) begin
                    ctrl.load_type = load_type_t'(funct3);
                end
            end
            OPC_STORE: begin
                ctrl.illegal = (funct3 > 3'b010);
                ctrl.dwen    = !ctrl.illegal;
                ctrl.b_sel   = B_IMM_S;
                if (!ctrl.illegal) begin
                    ctrl.load_type = load_type_t'(funct3);
                end
            end
            default: begin
                // ECALL encoding doubles as HALT
                ctrl.halt    = (instr == HALT_INSTR);
                ctrl.illegal = (instr != HALT_INSTR);
            end
        endcase
    end

endmodule

// File: hw/data_ram.sv
// Byte-enabled data memory
`timescale 1ns/1ns

module data_ram #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  rv32_exec_pkg::dbus_req_t req,
    output rv32_exec_pkg::word_t     rdata
);
    import rv32_exec_pkg::*;

    localparam int IDX_W = $clog2(DMEM_WORDS);

    word_t            mem [DMEM_WORDS];
    logic [IDX_W-1:0] idx;

    // Upper address bits wrap around the depth
    assign idx = req.addr[IDX_W+1:2];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            mem <= '{default: '0};
        end else if (req.wen) begin
            for (int b = 0; b < 4; b++) begin
                if (req.byte_en[b]) begin
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    assign rdata = req.ren ? mem[idx] : '0;

endmodule

// File: hw/exec_core.sv
// Execute core top level
`timescale 1ns/1ns

module exec_core #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                     CLK,
    input  logic                     nRST,
    input  rv32_exec_pkg::fetch_ex_t fetch_ex,
    input  logic                     stall,
    output rv32_exec_pkg::wb_t       wb,
    output rv32_exec_pkg::word_t     brj_addr,
    output logic                     mispredict,
    output rv32_exec_pkg::ex_exc_t   exc,
    output logic                     halt
);
    import rv32_exec_pkg::*;

    dbus_req_t dbus_req;
    word_t     dbus_rdata;

    execute_stage execute_stage_i (
        .CLK(CLK), .nRST(nRST), .fetch_ex(fetch_ex), .stall(stall),
        .dbus_req(dbus_req), .dbus_rdata(dbus_rdata), .wb(wb),
        .brj_addr(brj_addr), .mispredict(mispredict), .halt(halt), .exc(exc)
    );

    data_ram #(.DMEM_WORDS(DMEM_WORDS)) data_ram_i (
        .CLK(CLK), .nRST(nRST), .req(dbus_req), .rdata(dbus_rdata)
    );

endmodule

// File: hw/execute_stage.sv
// RV32I execute stage
`timescale 1ns/1ns

module execute_stage (
    input  logic                     CLK,
    input  logic                     nRST,
    input  rv32_exec_pkg::fetch_ex_t fetch_ex,
    input  logic                     stall,
    output rv32_exec_pkg::dbus_req_t dbus_req,
    input  rv32_exec_pkg::word_t     dbus_rdata,
    output rv32_exec_pkg::wb_t       wb,
    output rv32_exec_pkg::word_t     brj_addr,
    output logic                     mispredict,
    output logic                     halt,
    output rv32_exec_pkg::ex_exc_t   exc
);
    import rv32_exec_pkg::*;

    ctrl_t    ctrl;
    word_t    rs1_data, rs2_data;
    word_t    port_a, port_b, alu_out;
    word_t    pc4, target, load_ext, wdata;
    byte_en_t lanes;
    logic     taken, misaligned, commit_ok;

    control_decoder decoder_i (.instr(fetch_ex.instr), .ctrl(ctrl));

    reg_file reg_file_i (
        .CLK(CLK), .nRST(nRST), .rs1(ctrl.rs1), .rs2(ctrl.rs2),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .wb(wb)
    );

    alu alu_i (.aluop(ctrl.alu_op), .port_a(port_a), .port_b(port_b), .port_out(alu_out));

    branch_resolver branch_i (
        .rs1_data(rs1_data), .rs2_data(rs2_data), .pc(fetch_ex.pc),
        .ctrl(ctrl), .taken(taken), .target(target)
    );

    mem_lane_unit lane_i (
        .addr(alu_out), .store_data(rs2_data), .rdata(dbus_rdata),
        .load_type(ctrl.load_type), .req_lanes(lanes), .wdata(wdata),
        .load_ext(load_ext), .misaligned(misaligned)
    );

    assign pc4       = fetch_ex.pc + 32'd4;
    assign port_a    = (ctrl.a_sel == A_PC) ? fetch_ex.pc : rs1_data;
    assign port_b    = (ctrl.b_sel == B_RS2)   ? rs2_data   :
                       (ctrl.b_sel == B_IMM_I) ? ctrl.imm_i :
                       (ctrl.b_sel == B_IMM_S) ? ctrl.imm_s : ctrl.imm_u;
    assign commit_ok = !stall && !halt;

    always_comb begin
        case (ctrl.wb_sel)
            WB_LOAD:  wb.data = load_ext;
            WB_PC4:   wb.data = pc4;
            WB_IMM_U: wb.data = ctrl.imm_u;
            default:  wb.data = alu_out;
        endcase
    end

    assign wb.rd = ctrl.rd;
    assign wb.en = ctrl.reg_wen && commit_ok && !(ctrl.dren && misaligned);

    // Writes only leave the stage when the state may change
    assign dbus_req.ren     = ctrl.dren && !misaligned;
    assign dbus_req.wen     = ctrl.dwen && !misaligned && commit_ok;
    assign dbus_req.addr    = alu_out;
    assign dbus_req.wdata   = wdata;
    assign dbus_req.byte_en = lanes;

    assign brj_addr   = (ctrl.jal || ctrl.jalr || taken) ? target : pc4;
    assign mispredict = ctrl.branch && (fetch_ex.prediction ^ taken);

    assign exc.illegal   = ctrl.illegal;
    assign exc.mal_load  = ctrl.dren && misaligned;
    assign exc.mal_store = ctrl.dwen && misaligned;
    assign exc.addr      = alu_out;

    // Sticky until reset
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            halt <= 1'b0;
        end else if (ctrl.halt && !stall) begin
            halt <= 1'b1;
        end
    end

    a_dbus_excl: assert property (@(posedge CLK) disable iff (!nRST)
        !(dbus_req.ren && dbus_req.wen));

endmodule

// File: hw/mem_lane_unit.sv
// Data bus lane steering
`timescale 1ns/1ns

module mem_lane_unit (
    input  rv32_exec_pkg::word_t      addr,
    input  rv32_exec_pkg::word_t      store_data,
    input  rv32_exec_pkg::word_t      rdata,
    input  rv32_exec_pkg::load_type_t load_type,
    output rv32_exec_pkg::byte_en_t   req_lanes,
    output rv32_exec_pkg::word_t      wdata,
    output rv32_exec_pkg::word_t      load_ext,
    output logic                      misaligned
);
    import rv32_exec_pkg::*;

    logic [1:0] offset;
    word_t      lane_word;

    assign offset = addr[1:0];

    // Lanes stay off for a misaligned access
    always_comb begin
        req_lanes  = '0;
        wdata      = store_data;
        misaligned = 1'b0;
        case (load_type)
            LB, LBU: begin
                req_lanes = byte_en_t'(4'b0001 << offset);
                wdata     = {4{store_data[7:0]}};
            end
            LH, LHU: begin
                misaligned = offset[0];
                req_lanes  = offset[0] ? 4'b0000 : (offset[1] ? 4'b1100 : 4'b0011);
                wdata      = {2{store_data[15:0]}};
            end
            LW: begin
                misaligned = (offset != 2'b00);
                req_lanes  = misaligned ? 4'b0000 : 4'b1111;
            end
            default: req_lanes = '0;
        endcase
    end

    // Addressed byte or halfword moved down to bit 0
    assign lane_word = rdata >> {offset, 3'b000};

    always_comb begin
        case (load_type)
            LB:      load_ext = {{24{lane_word[7]}}, lane_word[7:0]};
            LBU:     load_ext = {24'b0, lane_word[7:0]};
            LH:      load_ext = {{16{lane_word[15]}}, lane_word[15:0]};
            LHU:     load_ext = {16'b0, lane_word[15:0]};
            default: load_ext = rdata;
        endcase
    end

    a_lanes_legal: assert final ($isunknown(addr) ||
        ((req_lanes inside {4'b0000, 4'b0001, 4'b0010, 4'b0100, 4'b1000,
                            4'b0011, 4'b1100, 4'b1111}) &&
         ((req_lanes == '0) == misaligned)))
        else $error("illegal byte enable pattern %b", req_lanes);

endmodule

// File: hw/reg_file.sv
// Integer register file
`timescale 1ns/1ns

module reg_file (
    input  logic                     CLK,
    input  logic                     nRST,
    input  rv32_exec_pkg::reg_addr_t rs1,
    input  rv32_exec_pkg::reg_addr_t rs2,
    output rv32_exec_pkg::word_t     rs1_data,
    output rv32_exec_pkg::word_t     rs2_data,
    input  rv32_exec_pkg::wb_t       wb
);
    import rv32_exec_pkg::*;

    word_t regs [32];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            regs <= '{default: '0};
        end else if (wb.en && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    // x0 stays zero whatever was written to it before
    a_x0_zero: assert property (@(posedge CLK) disable iff (!nRST)
        ((rs1 == '0) |-> (rs1_data == '0)) and ((rs2 == '0) |-> (rs2_data == '0)));

endmodule

// File: hw/rv32_exec_pkg.sv
// RV32I execute stage types
package rv32_exec_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_en_t;

    // Encoded as {instr[30], funct3}
    typedef enum logic [3:0] {
        ADD  = 4'b0000,
        SUB  = 4'b1000,
        SLL  = 4'b0001,
        SLT  = 4'b0010,
        SLTU = 4'b0011,
        XOR  = 4'b0100,
        SRL  = 4'b0101,
        SRA  = 4'b1101,
        OR   = 4'b0110,
        AND  = 4'b0111
    } alu_op_t;

    // Holds funct3, shared by loads and stores
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_type_t;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_type_t;

    typedef enum logic {A_RS1, A_PC} a_sel_t;
    typedef enum logic [1:0] {B_RS2, B_IMM_I, B_IMM_S, B_IMM_U} b_sel_t;
    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC4, WB_IMM_U} wb_sel_t;

    typedef struct packed {
        word_t instr;
        word_t pc;
        logic  prediction;
    } fetch_ex_t;

    typedef struct packed {
        alu_op_t      alu_op;
        a_sel_t       a_sel;
        b_sel_t       b_sel;
        wb_sel_t      wb_sel;
        logic         reg_wen;
        logic         dren;
        logic         dwen;
        load_type_t   load_type;
        branch_type_t branch_type;
        logic         branch;
        logic         jal;
        logic         jalr;
        logic         halt;
        logic         illegal;
        reg_addr_t    rs1;
        reg_addr_t    rs2;
        reg_addr_t    rd;
        word_t        imm_i;
        word_t        imm_s;
        word_t        imm_b;
        word_t        imm_u;
        word_t        imm_j;
    } ctrl_t;

    typedef struct packed {
        logic     ren;
        logic     wen;
        word_t    addr;
        word_t    wdata;
        byte_en_t byte_en;
    } dbus_req_t;

    typedef struct packed {
        logic      en;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    typedef struct packed {
        logic  illegal;
        logic  mal_load;
        logic  mal_store;
        word_t addr;
    } ex_exc_t;

endpackage

// File: tests/tb_exec_core.sv
// Execute core testbench
`timescale 1ns/1ns

module tb_exec_core;
    import rv32_exec_pkg::*;

    localparam int DMEM_WORDS = 64;
    localparam int MEM_BYTES  = DMEM_WORDS * 4;
    localparam int N_ALU      = 300;
    localparam int N_MEM      = 100;
    localparam int N_BRJ      = 200;
    localparam int N_MAL      = 50;
    localparam int N_TAIL     = 10;
    // Memory steps take three cycles, misaligned steps two instructions
    localparam int N_INSTR    = N_ALU + 3 * N_MEM + N_BRJ + 2 * N_MAL + 1 + 4 * N_TAIL;
    // One stall per four instructions on average, then twice that
    localparam int TIMEOUT_CYCLES = 2 * (N_INSTR * 5 / 4 + 8);

    logic      CLK;
    logic      nRST;
    logic      stall;
    logic      mispredict;
    logic      halt;
    fetch_ex_t fetch_ex;
    wb_t       wb;
    word_t     brj_addr;
    ex_exc_t   exc;

    // Reference model state
    word_t      mregs [32];
    logic [7:0] mbytes [MEM_BYTES];
    logic       mhalt;
    word_t      rng = 32'h2996;
    word_t      pc;
    int         cycle_count = 0;

    // Expected outputs for the instruction now on the inputs
    logic       exp_wb_en, exp_check_data, exp_mispredict, exp_halt;
    logic       exp_illegal, exp_mal_load, exp_mal_store;
    reg_addr_t  exp_rd;
    word_t      exp_data, exp_brj, exp_addr;
    // State change due at the next edge
    logic       store_ok, halt_req;
    logic [2:0] st_f3;
    word_t      st_addr, st_data;

    exec_core #(.DMEM_WORDS(DMEM_WORDS)) exec_core_i (
        .CLK(CLK), .nRST(nRST), .fetch_ex(fetch_ex), .stall(stall), .wb(wb),
        .brj_addr(brj_addr), .mispredict(mispredict), .exc(exc), .halt(halt)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    task automatic stop_on_failure();
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic value_error(input string name, input word_t expected, input word_t actual);
        $display("ERROR: %s expected %h actual %h", name, expected, actual);
        stop_on_failure();
    endtask

    function automatic word_t rand32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0: begin
                if (alt) return a - b;
                return a + b;
            end
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Word from the byte model, shifted so the addressed byte sits at bit 0
    function automatic word_t load_ref(logic [2:0] f3, word_t addr);
        int    widx;
        word_t w;
        widx = (addr % MEM_BYTES) & ~3;
        w = {mbytes[widx + 3], mbytes[widx + 2], mbytes[widx + 1], mbytes[widx]};
        w = w >> (8 * addr[1:0]);
        case (f3)
            3'd0: return {{24{w[7]}}, w[7:0]};
            3'd1: return {{16{w[15]}}, w[15:0]};
            3'd4: return {24'b0, w[7:0]};
            3'd5: return {16'b0, w[15:0]};
            default: return w;
        endcase
    endfunction

    function automatic logic misaligned_ref(logic [2:0] f3, word_t addr);
        return (f3[1:0] == 2'b01) ? addr[0] : (f3[1:0] == 2'b10) ? (addr[1:0] != 2'b00) : 1'b0;
    endfunction

    task automatic predict();
        word_t      ins, a, b, ii, is, ib, iu, ij, pc4, addr;
        logic [6:0] opc;
        logic [2:0] f3;
        logic       wr, mis, taken, is_store;
        ins = fetch_ex.instr;
        opc = ins[6:0];
        f3  = ins[14:12];
        a   = mregs[ins[19:15]];
        b   = mregs[ins[24:20]];
        ii  = {{20{ins[31]}}, ins[31:20]};
        is  = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        ib  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        iu  = {ins[31:12], 12'b0};
        ij  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        pc4 = fetch_ex.pc + 32'd4;
        exp_rd = ins[11:7];
        exp_data = '0;
        exp_brj = pc4;
        exp_mispredict = 1'b0;
        exp_illegal = 1'b0;
        exp_mal_load = 1'b0;
        exp_mal_store = 1'b0;
        wr = 1'b0;
        mis = 1'b0;
        is_store = 1'b0;
        halt_req = 1'b0;
        addr = '0;
        case (opc)
            7'h33: begin
                exp_data = alu_ref(f3, ins[30], a, b);
                wr = 1'b1;
            end
            7'h13: begin
                exp_data = alu_ref(f3, ins[30] && (f3 == 3'd5), a, ii);
                wr = 1'b1;
            end
            7'h37: begin
                exp_data = iu;
                wr = 1'b1;
            end
            7'h17: begin
                exp_data = fetch_ex.pc + iu;
                wr = 1'b1;
            end
            7'h6f: begin
                exp_data = pc4;
                exp_brj = fetch_ex.pc + ij;
                wr = 1'b1;
            end
            7'h67: begin
                exp_data = pc4;
                exp_brj = (a + ii) & ~32'd1;
                wr = 1'b1;
            end
            7'h63: begin
                taken = branch_ref(f3, a, b);
                if (taken) exp_brj = fetch_ex.pc + ib;
                exp_mispredict = fetch_ex.prediction ^ taken;
            end
            7'h03: begin
                addr = a + ii;
                mis = misaligned_ref(f3, addr);
                exp_mal_load = mis;
                exp_data = load_ref(f3, addr);
                wr = 1'b1;
            end
            7'h23: begin
                addr = a + is;
                mis = misaligned_ref(f3, addr);
                exp_mal_store = mis;
                is_store = !mis;
            end
            default: begin
                // ECALL encoding is the HALT instruction
                halt_req = (ins == 32'h0000_0073);
                exp_illegal = (ins != 32'h0000_0073);
            end
        endcase
        exp_addr = addr;
        exp_check_data = wr && !mis;
        exp_wb_en = wr && !mis && !stall && !mhalt;
        exp_halt = mhalt;
        store_ok = is_store && !stall && !mhalt;
        halt_req = halt_req && !stall;
        st_f3 = f3;
        st_addr = addr;
        st_data = b;
    endtask

    task automatic commit();
        int nbytes;
        int idx;
        if (exp_wb_en && (exp_rd != '0)) mregs[exp_rd] = exp_data;
        if (store_ok) begin
            nbytes = 1 << st_f3[1:0];
            idx = st_addr % MEM_BYTES;
            for (int k = 0; k < nbytes; k++) begin
                mbytes[idx + k] = st_data[8*k +: 8];
            end
        end
        if (halt_req) mhalt = 1'b1;
    endtask

    // Drive one cycle, called 10 ns after a rising edge
    task automatic apply(input word_t instr, input logic pred, input logic stall_bit);
        fetch_ex.instr = instr;
        fetch_ex.pc = pc;
        fetch_ex.prediction = pred;
        stall = stall_bit;
        predict();
        @(posedge CLK);
        commit();
        #10;
    endtask

    task automatic issue(input word_t instr, input logic pred);
        if ((rand32() & 32'd3) == 32'd0) apply(instr, pred, 1'b1);
        apply(instr, pred, 1'b0);
        pc = pc + 32'd4;
    endtask

    function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3, reg_addr_t rd, logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic gen_alu();
        word_t      r, r2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        r = rand32();
        r2 = rand32();
        f3 = r[10:8];
        case (r[2:0])
            3'd4, 3'd5: begin
                // Shift immediates carry funct7 in the upper bits
                if (f3 == 3'd1) imm = {7'h00, r[16:12]};
                else if (f3 == 3'd5) imm = {r[11] ? 7'h20 : 7'h00, r[16:12]};
                else imm = r2[11:0];
                issue(enc_i(imm, r[21:17], f3, r[26:22], 7'h13), 1'b0);
            end
            3'd6: issue({r2[19:0], r[26:22], 7'h37}, 1'b0);
            3'd7: issue({r2[19:0], r[26:22], 7'h17}, 1'b0);
            default: begin
                f7 = ((f3 == 3'd0 || f3 == 3'd5) && r[11]) ? 7'h20 : 7'h00;
                issue(enc_r(f7, r[16:12], r[21:17], f3, r[26:22], 7'h33), 1'b0);
            end
        endcase
    endtask

    // Store, then a load of any width from the same word
    task automatic gen_mem_pair();
        word_t       r, r2;
        reg_addr_t   base;
        logic [2:0]  sf3, lf3, pick;
        logic [1:0]  soff, loff;
        logic [11:0] imm_s, imm_l;
        r = rand32();
        r2 = rand32();
        base = r[4:0];
        sf3 = 3'(r[6:5] % 2'd3);
        soff = (sf3 == 3'd0) ? r[8:7] : (sf3 == 3'd1) ? {r[8], 1'b0} : 2'b00;
        imm_s = {r2[11:2], 2'(soff - mregs[base][1:0])};
        issue(enc_s(imm_s, r[13:9], base, sf3), 1'b0);
        // Stalled store of other data to the same bytes
        apply(enc_s(imm_s, r[13:9] ^ 5'd1, base, sf3), 1'b0, 1'b1);
        pick = r[16:14] % 3'd5;
        lf3 = (pick < 3'd3) ? pick : pick + 3'd1;
        loff = (lf3[1:0] == 2'b00) ? r[18:17] : (lf3[1:0] == 2'b01) ? {r[18], 1'b0} : 2'b00;
        imm_l = imm_s - 12'(soff) + 12'(loff);
        issue(enc_i(imm_l, base, lf3, r[23:19], 7'h03), 1'b0);
    endtask

    task automatic gen_brj();
        word_t      r, r2;
        logic [2:0] f3;
        reg_addr_t  rs1;
        r = rand32();
        r2 = rand32();
        rs1 = r[9:5];
        case (r[1:0])
            2'd2: issue(enc_j({r2[20:1], 1'b0}, r[14:10]), r[15]);
            2'd3: issue(enc_i(r2[11:0], rs1, 3'b000, r[14:10], 7'h67), r[15]);
            default: begin
                f3 = r[4:2];
                if (f3[2:1] == 2'b01) f3 = {1'b1, f3[1:0]};
                issue(enc_b({r2[12:1], 1'b0}, r[16] ? rs1 : r[14:10], rs1, f3), r[15]);
            end
        endcase
    endtask

    // Misaligned access, then a read back of the state it must not touch
    task automatic gen_misaligned(input int step);
        word_t       r, r2;
        reg_addr_t   base, rd;
        logic [2:0]  f3;
        logic [1:0]  off;
        logic [11:0] imm;
        r = rand32();
        r2 = rand32();
        base = r[4:0];
        rd = r[9:5];
        if (step % 10 == 9) begin
            issue({r2[31:7], 7'b0001011}, 1'b0);
        end else begin
            f3 = r[11] ? 3'b010 : (r[10] && r[12]) ? 3'b101 : 3'b001;
            off = !r[11] ? {r[13], 1'b1} : (r[14:13] == 2'b00) ? 2'b11 : r[14:13];
            imm = {r2[11:2], 2'(off - mregs[base][1:0])};
            if (r[10]) begin
                issue(enc_i(imm, base, f3, rd, 7'h03), 1'b0);
                issue(enc_r(7'h00, 5'd0, rd, 3'b110, r[19:15], 7'h33), 1'b0);
            end else begin
                issue(enc_s(imm, r[19:15], base, f3), 1'b0);
                issue(enc_i(imm - 12'(off), base, 3'b010, r[24:20], 7'h03), 1'b0);
            end
        end
    endtask

    a_wb_en: assert property (@(posedge CLK) disable iff (!nRST) wb.en == exp_wb_en)
        else value_error("wb.en", 32'($sampled(exp_wb_en)), 32'($sampled(wb.en)));
    a_wb_rd: assert property (@(posedge CLK) disable iff (!nRST)
        exp_check_data |-> (wb.rd == exp_rd))
        else value_error("wb.rd", 32'($sampled(exp_rd)), 32'($sampled(wb.rd)));
    a_wb_data: assert property (@(posedge CLK) disable iff (!nRST)
        exp_check_data |-> (wb.data == exp_data))
        else value_error("wb.data", $sampled(exp_data), $sampled(wb.data));
    a_brj_addr: assert property (@(posedge CLK) disable iff (!nRST) brj_addr == exp_brj)
        else value_error("brj_addr", $sampled(exp_brj), $sampled(brj_addr));
    a_mispredict: assert property (@(posedge CLK) disable iff (!nRST)
        mispredict == exp_mispredict)
        else value_error("mispredict", 32'($sampled(exp_mispredict)), 32'($sampled(mispredict)));
    a_illegal: assert property (@(posedge CLK) disable iff (!nRST) exc.illegal == exp_illegal)
        else value_error("exc.illegal", 32'($sampled(exp_illegal)), 32'($sampled(exc.illegal)));
    a_mal_load: assert property (@(posedge CLK) disable iff (!nRST)
        exc.mal_load == exp_mal_load)
        else value_error("exc.mal_load", 32'($sampled(exp_mal_load)),
                         32'($sampled(exc.mal_load)));
    a_mal_store: assert property (@(posedge CLK) disable iff (!nRST)
        exc.mal_store == exp_mal_store)
        else value_error("exc.mal_store", 32'($sampled(exp_mal_store)),
                         32'($sampled(exc.mal_store)));
    a_exc_addr: assert property (@(posedge CLK) disable iff (!nRST)
        (exp_mal_load || exp_mal_store) |-> (exc.addr == exp_addr))
        else value_error("exc.addr", $sampled(exp_addr), $sampled(exc.addr));
    a_halt: assert property (@(posedge CLK) disable iff (!nRST) halt == exp_halt)
        else value_error("halt", 32'($sampled(exp_halt)), 32'($sampled(halt)));

    always @(posedge CLK) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the test did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_on_failure();
        end
    end

    initial begin
        nRST = 1'b0;
        stall = 1'b0;
        fetch_ex = '0;
        fetch_ex.instr = 32'h0000_0013;
        pc = 32'h0000_1000;
        mhalt = 1'b0;
        foreach (mregs[i]) mregs[i] = '0;
        foreach (mbytes[i]) mbytes[i] = '0;
        repeat (2) @(posedge CLK);
        #10;
        nRST = 1'b1;
        for (int i = 0; i < N_ALU; i++) gen_alu();
        for (int i = 0; i < N_MEM; i++) gen_mem_pair();
        for (int i = 0; i < N_BRJ; i++) gen_brj();
        for (int i = 0; i < N_MAL; i++) gen_misaligned(i);
        issue(32'h0000_0073, 1'b0);
        // Nothing may commit once halted, loads read back the frozen memory
        for (int i = 0; i < N_TAIL; i++) begin
            gen_alu();
            gen_mem_pair();
        end
        if (mhalt) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("Halt was never reached by the reference model");
            stop_on_failure();
        end
    end

endmodule
